/* all.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/controlUnit.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memoryStage.sv
rtl/mips.sv
sim/clockGen.sv
sim/mips_assert.sv
sim/tb_mips.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mips
SEED ?= 91922
BUILD ?= obj_dir
FILELIST ?= all.f
VFLAGS ?= --timing --assert

SOURCES := $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD)

/* sim/mips_golden.txt */
// header: program word count, record count; then the program words
// records: test kind key data; kind 1 retire (key = reg), 2 store (key = address),
// kind 3 retire with generated immediate (data = program word index)
00000031 0000001F
2401FFFB 340200F0 3C031234 00012100 00222821 00623023 00223824
00234025 0022482A 0041502A 340B0000 240C0000 AC460010 AC080004
8C4D0010 8C0E0004 10280002 240F0001 241007FF 14280002 24110002
24120003 14220002 24130004 241007FF 10220002 24140005 24150006
0C000021 24160007 24170008 08000025 00000000 00000000 03E00008
24180009 241007FF 04310002 2419000A 241A000B 04510002 241B000C
241007FF 24000055 00000000 00000000 0000E021 0800002F 00000000
// alu
1 1 01 FFFFFFFB   1 1 02 000000F0
1 1 03 12340000   1 1 04 FFFFFFB0
1 1 05 000000EB   1 1 06 1233FF10
1 1 07 000000F0   1 1 08 FFFFFFFB
1 1 09 00000001   1 1 0A 00000000
1 3 0B 0000000A   1 3 0C 0000000B
// memory
2 2 00000100 1233FF10   2 2 00000004 FFFFFFFB
2 1 0D 1233FF10   2 1 0E FFFFFFFB
// branch
3 1 0F 00000001   3 1 11 00000002   3 1 12 00000003
3 1 13 00000004   3 1 14 00000005   3 1 15 00000006
// jump, bgezal, zero
4 1 1F 00000078   4 1 16 00000007   4 1 18 00000009   4 1 17 00000008
5 1 19 0000000A   5 1 1A 0000000B   5 1 1F 000000A8   5 1 1B 0000000C
6 1 1C 00000000

/* sim/tb_mips.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module tb_mips #(
    parameter int SEED = 91922
);
    localparam int EVENT_TIMEOUT = 200;
    localparam int MAX_RECORDS = 64;

    typedef struct packed {
        mipsPkg::word_t kind;
        mipsPkg::word_t key;
        mipsPkg::word_t data;
        mipsPkg::word_t pc;
    } event_t;

    typedef struct packed {
        mipsPkg::word_t test;
        mipsPkg::word_t kind;  // 1 retire, 2 store, 3 retire with generated operand
        mipsPkg::word_t key;
        mipsPkg::word_t data;
    } record_t;

    logic clk;
    logic reset;
    mipsPkg::imemLoad_t imemLoad;
    mipsPkg::retire_t retire;
    mipsPkg::store_t store;

    mipsPkg::word_t golden [512];
    mipsPkg::word_t prog [`IMEM_WORDS];
    record_t records [MAX_RECORDS];
    event_t observed [$];
    int progWords;
    int recCount;
    int checkCount;
    int errorCount;
    int testChecks;
    int testErrors;
    int testsDone;

    clockGen clock0 (
        .clk(clk)
    );

    mips dut0 (
        .clk(clk),
        .reset(reset),
        .imemLoad(imemLoad),
        .retire(retire),
        .store(store)
    );

    function automatic string testName(input mipsPkg::word_t id);
        case (id)
            1: return "alu";
            2: return "memory";
            3: return "branch";
            4: return "jump";
            5: return "bgezal";
            6: return "zero";
            default: return "unknown";
        endcase
    endfunction

    // destination register by instruction format
    function automatic mipsPkg::regNum_t destOf(input mipsPkg::word_t instr);
        case (instr[31:26])
            `OP_SPECIAL: return instr[15:11];
            `OP_JAL, `OP_REGIMM: return 5'd31;
            default: return instr[20:16];
        endcase
    endfunction

    task automatic compareValue(input string label, input mipsPkg::word_t expected,
                                input mipsPkg::word_t actual);
        checkCount++;
        testChecks++;
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", label, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportTest(input mipsPkg::word_t id);
        $display("test %s finished: %0d checks, %0d errors", testName(id), testChecks,
                 testErrors);
        testsDone++;
        testChecks = 0;
        testErrors = 0;
    endtask

    // writeback is older than the store in the same cycle, so it goes first
    task automatic sampleEvents();
        event_t ev;
        @(negedge clk);
        if (retire.valid) begin
            ev = '{kind: 32'd1, key: 32'(retire.regNum), data: retire.data, pc: retire.pc};
            observed.push_back(ev);
        end
        if (store.valid) begin
            ev = '{kind: 32'd2, key: store.address, data: store.data, pc: 32'd0};
            observed.push_back(ev);
        end
    endtask

    task automatic waitEvent(output event_t ev, output logic found);
        int cycles;
        cycles = 0;
        ev = '0;
        found = 1'b0;
        while (observed.size() == 0 && cycles < EVENT_TIMEOUT) begin
            sampleEvents();
            cycles++;
        end
        if (observed.size() > 0) begin
            ev = observed.pop_front();
            found = 1'b1;
        end
    endtask

    // random immediates for ori/addiu from $0, expected value per the extension rule
    task automatic generateOperands();
        int r;
        int idx;
        mipsPkg::word_t imm;
        for (r = 0; r < recCount; r++) begin
            if (records[r].kind == 32'd3) begin
                idx = int'(records[r].data);
                imm = $urandom & 32'h0000_FFFF;
                prog[idx] = {prog[idx][31:16], imm[15:0]};
                records[r].kind = 32'd1;
                if (prog[idx][31:26] == `OP_ORI) begin
                    records[r].data = {16'h0000, imm[15:0]};
                end else begin
                    records[r].data = {{16{imm[15]}}, imm[15:0]};
                end
            end
        end
    endtask

    initial begin
        int i;
        int r;
        int base;
        mipsPkg::word_t curTest;
        event_t ev;
        logic found;
        logic timedOut;

        reset = 1'b1;
        imemLoad = '0;
        checkCount = 0;
        errorCount = 0;
        testChecks = 0;
        testErrors = 0;
        testsDone = 0;
        timedOut = 1'b0;
        void'($urandom(SEED));

        $readmemh("sim/mips_golden.txt", golden);
        progWords = int'(golden[0]);
        recCount = int'(golden[1]);
        for (i = 0; i < progWords; i++) begin
            prog[i] = golden[2 + i];
        end
        base = 2 + progWords;
        for (r = 0; r < recCount; r++) begin
            records[r] = {golden[base + 4 * r], golden[base + 4 * r + 1],
                          golden[base + 4 * r + 2], golden[base + 4 * r + 3]};
        end
        generateOperands();

        // program load while reset is held
        for (i = 0; i < progWords; i++) begin
            @(negedge clk);
            imemLoad = '{valid: 1'b1, address: 32'(i * 4), data: prog[i]};
        end
        @(negedge clk);
        imemLoad = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        curTest = records[0].test;
        for (r = 0; r < recCount && !timedOut; r++) begin
            if (records[r].test != curTest) begin
                reportTest(curTest);
                curTest = records[r].test;
            end
            waitEvent(ev, found);
            if (!found) begin
                $display("test %s: %s %0d (key %h) never came within %0d cycles",
                         testName(curTest), records[r].kind == 32'd2 ? "store" : "retire",
                         r, records[r].key, EVENT_TIMEOUT);
                errorCount++;
                testErrors++;
                timedOut = 1'b1;
            end else begin
                compareValue($sformatf("%s record %0d kind", testName(curTest), r),
                             records[r].kind, ev.kind);
                compareValue($sformatf("%s record %0d key", testName(curTest), r),
                             records[r].key, ev.key);
                compareValue($sformatf("%s record %0d data", testName(curTest), r),
                             records[r].data, ev.data);
                // the retired pc must hold an instruction that targets this register
                if (records[r].kind == 32'd1 && ev.kind == 32'd1) begin
                    compareValue($sformatf("%s record %0d dest at pc %h", testName(curTest),
                                           r, ev.pc),
                                 records[r].key, 32'(destOf(prog[ev.pc[9:2]])));
                end
            end
        end
        reportTest(curTest);

        // the closing self loop must stay silent
        if (!timedOut) begin
            for (i = 0; i < 20; i++) begin
                sampleEvents();
            end
            while (observed.size() > 0) begin
                ev = observed.pop_front();
                $display("unexpected event after the last record: kind %0d, key %h, data %h",
                         ev.kind, ev.key, ev.data);
                errorCount++;
            end
        end
        errorCount += dut0.mipsChecks.failCount;

        $display("%0d tests, %0d checks, %0d errors", testsDone, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mips_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_assert (
    input wire clk,
    input wire reset,
    input wire mipsPkg::retire_t retire,
    input wire mipsPkg::store_t store
);
    int failCount = 0;  // read by the testbench at the end

    quietInReset: assert property (@(posedge clk)
        reset && $past(reset) |-> !retire.valid && !store.valid)
        else begin
            failCount++;
            $error("retire or store valid while reset is held");
        end

    noRetireToZero: assert property (@(posedge clk) retire.valid |-> retire.regNum != 5'd0)
        else begin
            failCount++;
            $error("retire names register 0");
        end

    storeAligned: assert property (@(posedge clk) store.valid |-> store.address[1:0] == 2'b00)
        else begin
            failCount++;
            $error("store address is not word aligned");
        end

endmodule

bind mips mips_assert mipsChecks (
    .clk(clk),
    .reset(reset),
    .retire(retire),
    .store(store)
);

`default_nettype wire

/* sim/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk
);
    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* rtl/mips.sv */
`timescale 1ns/1ps
`default_nettype none

module mips (
    input  wire clk,
    input  wire reset,
    input  wire mipsPkg::imemLoad_t imemLoad,
    output mipsPkg::retire_t retire,
    output mipsPkg::store_t store
);
    wire mipsPkg::word_t nextPc;
    wire mipsPkg::fdStage_t fd;
    wire mipsPkg::deStage_t de;
    wire mipsPkg::emStage_t em;
    wire mipsPkg::mwStage_t mw;  // also feeds writeback in decode

    fetch fetch0 (
        .clk(clk),
        .reset(reset),
        .imemLoad(imemLoad),
        .nextPc(nextPc),
        .fd(fd)
    );

    decode decode0 (
        .clk(clk),
        .reset(reset),
        .fd(fd),
        .mw(mw),
        .nextPc(nextPc),
        .de(de),
        .retire(retire)
    );

    execute execute0 (
        .clk(clk),
        .reset(reset),
        .de(de),
        .em(em)
    );

    memoryStage memory0 (
        .clk(clk),
        .reset(reset),
        .em(em),
        .mw(mw),
        .store(store)
    );

endmodule

`default_nettype wire

/* rtl/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module memoryStage (
    input  wire clk,
    input  wire reset,
    input  wire mipsPkg::emStage_t em,
    output mipsPkg::mwStage_t mw,
    output mipsPkg::store_t store
);
    mipsPkg::ctrl_t ctrl;
    mipsPkg::word_t dmem [`DMEM_WORDS];
    logic [7:0] index;

    controlUnit memCtrl (
        .instr(em.instr),
        .ctrl(ctrl)
    );

    assign index = em.aluResult[9:2];  // word index, low bits ignored

    always_ff @(posedge clk) begin
        if (ctrl.memWrite) begin
            dmem[index] <= em.rtData;
        end
    end

    // store trace
    assign store = '{valid: ctrl.memWrite, address: em.aluResult, data: em.rtData};

    always_ff @(posedge clk) begin
        if (reset) begin
            mw <= '0;
        end else begin
            mw.pc <= em.pc;
            mw.instr <= em.instr;
            mw.aluResult <= em.aluResult;
            mw.memData <= ctrl.memRead ? dmem[index] : '0;
            mw.linkTaken <= em.linkTaken;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module execute (
    input  wire clk,
    input  wire reset,
    input  wire mipsPkg::deStage_t de,
    output mipsPkg::emStage_t em
);
    mipsPkg::ctrl_t ctrl;
    mipsPkg::word_t opA;
    mipsPkg::word_t opB;
    mipsPkg::word_t result;

    controlUnit execCtrl (
        .instr(de.instr),
        .ctrl(ctrl)
    );

    assign opA = (ctrl.aluOp == `ALU_SLL) ? de.rtData : de.rsData;  // sll shifts rt

    always_comb begin
        case (ctrl.aluSrcB)
            `SRCB_IMM: opB = de.imm;
            `SRCB_SHAMT: opB = {27'd0, de.instr[10:6]};
            default: opB = de.rtData;
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            `ALU_SUBU: result = opA - opB;
            `ALU_AND: result = opA & opB;
            `ALU_OR: result = opA | opB;
            `ALU_SLT: result = {31'd0, $signed(opA) < $signed(opB)};
            `ALU_SLL: result = opA << opB[4:0];
            `ALU_LUI: result = opB;  // already shifted by decode
            default: result = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            em <= '0;
        end else begin
            em <= '{pc: de.pc, instr: de.instr, rtData: de.rtData,
                    aluResult: result, linkTaken: de.linkTaken};
        end
    end

endmodule

`default_nettype wire

/* rtl/decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module decode (
    input  wire clk,
    input  wire reset,
    input  wire mipsPkg::fdStage_t fd,
    input  wire mipsPkg::mwStage_t mw,
    output mipsPkg::word_t nextPc,
    output mipsPkg::deStage_t de,
    output mipsPkg::retire_t retire
);
    mipsPkg::ctrl_t dCtrl;
    mipsPkg::ctrl_t wCtrl;
    mipsPkg::word_t regs [32];
    mipsPkg::regNum_t rs;
    mipsPkg::regNum_t rt;
    mipsPkg::word_t rsData;
    mipsPkg::word_t rtData;
    mipsPkg::word_t imm;
    mipsPkg::word_t pcPlus4;
    mipsPkg::word_t branchTarget;
    mipsPkg::word_t jumpTarget;
    logic taken;
    logic linkTaken;
    mipsPkg::regNum_t wbNum;
    mipsPkg::word_t wbData;
    logic wbEnable;

    controlUnit decodeCtrl (
        .instr(fd.instr),
        .ctrl(dCtrl)
    );

    controlUnit writebackCtrl (
        .instr(mw.instr),
        .ctrl(wCtrl)
    );

    // writeback side
    always_comb begin
        case (wCtrl.regDst)
            `DST_RD: wbNum = mw.instr[15:11];
            `DST_RA: wbNum = 5'd31;
            default: wbNum = mw.instr[20:16];
        endcase
        case (wCtrl.regSrc)
            `WB_MEM: wbData = mw.memData;
            `WB_LINK: wbData = mw.pc + 32'd8;
            default: wbData = mw.aluResult;
        endcase
    end

    // bgezal links only if its compare held back in decode
    assign wbEnable = wCtrl.regWrite && (wbNum != 5'd0)
                      && ((wCtrl.branch != `BR_BGEZAL) || mw.linkTaken);

    always_ff @(posedge clk) begin
        if (wbEnable) begin
            regs[wbNum] <= wbData;
        end
    end

    assign retire = '{valid: wbEnable, pc: mw.pc, regNum: wbNum, data: wbData};

    // register read, $0 hardwired, same-cycle write passes through
    assign rs = fd.instr[25:21];
    assign rt = fd.instr[20:16];
    assign rsData = (rs == 5'd0) ? '0 : (wbEnable && wbNum == rs) ? wbData : regs[rs];
    assign rtData = (rt == 5'd0) ? '0 : (wbEnable && wbNum == rt) ? wbData : regs[rt];

    always_comb begin
        case (dCtrl.extOp)
            `EXT_SIGN: imm = {{16{fd.instr[15]}}, fd.instr[15:0]};
            `EXT_UPPER: imm = {fd.instr[15:0], 16'h0000};
            default: imm = {16'h0000, fd.instr[15:0]};
        endcase
    end

    // branch compare and next pc
    assign linkTaken = (dCtrl.branch == `BR_BGEZAL) && !rsData[31];

    always_comb begin
        case (dCtrl.branch)
            `BR_BEQ: taken = (rsData == rtData);
            `BR_BNE: taken = (rsData != rtData);
            `BR_BGEZAL: taken = linkTaken;
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4 = fd.pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{fd.instr[15]}}, fd.instr[15:0], 2'b00};
    assign jumpTarget = {pcPlus4[31:28], fd.instr[25:0], 2'b00};

    always_comb begin
        if (dCtrl.jump == `JMP_INDEX) begin
            nextPc = jumpTarget;
        end else if (dCtrl.jump == `JMP_REG) begin
            nextPc = rsData;
        end else if (taken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4 + 32'd4;  // fall through past the delay slot
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            de <= '0;
        end else begin
            de <= '{pc: fd.pc, instr: fd.instr, rsData: rsData, rtData: rtData,
                    imm: imm, linkTaken: linkTaken};
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module fetch (
    input  wire clk,
    input  wire reset,
    input  wire mipsPkg::imemLoad_t imemLoad,
    input  wire mipsPkg::word_t nextPc,
    output mipsPkg::fdStage_t fd
);
    mipsPkg::word_t pc;
    mipsPkg::word_t pcNext;
    mipsPkg::word_t imem [`IMEM_WORDS];

    // decode reports fd.pc + 8 when it does not redirect,
    // so fetch keeps its own sequence (covers the delay slot and the reset bubble)
    assign pcNext = (nextPc == fd.pc + 32'd8) ? pc + 32'd4 : nextPc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
            fd <= '0;
        end else begin
            pc <= pcNext;
            fd.pc <= pc;
            fd.instr <= imem[pc[9:2]];
        end
    end

    // program load, only while held in reset
    always_ff @(posedge clk) begin
        if (reset && imemLoad.valid) begin
            imem[imemLoad.address[9:2]] <= imemLoad.data;
        end
    end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module controlUnit (
    input  wire mipsPkg::word_t instr,
    output mipsPkg::ctrl_t ctrl
);
    logic [5:0] opcode;
    logic [5:0] funct;
    mipsPkg::regNum_t rt;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rt = instr[20:16];

    always_comb begin
        ctrl = '0;  // unknown encodings stay inert
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FN_SLL: begin
                        ctrl.aluOp = `ALU_SLL;
                        ctrl.aluSrcB = `SRCB_SHAMT;
                    end
                    `FN_ADDU: ctrl.aluOp = `ALU_ADDU;
                    `FN_SUBU: ctrl.aluOp = `ALU_SUBU;
                    `FN_AND: ctrl.aluOp = `ALU_AND;
                    `FN_OR: ctrl.aluOp = `ALU_OR;
                    `FN_SLT: ctrl.aluOp = `ALU_SLT;
                    `FN_JR: ctrl.jump = `JMP_REG;
                    default: ;
                endcase
                // every R-type here except jr writes rd
                if (funct inside {`FN_SLL, `FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_SLT}) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst = `DST_RD;
                end
            end
            `OP_REGIMM: begin
                if (rt == `RT_BGEZAL) begin
                    ctrl.branch = `BR_BGEZAL;
                    ctrl.regWrite = 1'b1;  // gated later by linkTaken
                    ctrl.regDst = `DST_RA;
                    ctrl.regSrc = `WB_LINK;
                end
            end
            `OP_J: ctrl.jump = `JMP_INDEX;
            `OP_JAL: begin
                ctrl.jump = `JMP_INDEX;
                ctrl.regWrite = 1'b1;
                ctrl.regDst = `DST_RA;
                ctrl.regSrc = `WB_LINK;
            end
            `OP_BEQ: ctrl.branch = `BR_BEQ;
            `OP_BNE: ctrl.branch = `BR_BNE;
            `OP_ADDIU, `OP_ORI, `OP_LUI, `OP_LW: begin
                ctrl.aluSrcB = `SRCB_IMM;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = (opcode == `OP_ORI) ? `ALU_OR
                           : (opcode == `OP_LUI) ? `ALU_LUI : `ALU_ADDU;
                ctrl.extOp = (opcode == `OP_ORI) ? `EXT_ZERO
                           : (opcode == `OP_LUI) ? `EXT_UPPER : `EXT_SIGN;
                if (opcode == `OP_LW) begin
                    ctrl.memRead = 1'b1;
                    ctrl.regSrc = `WB_MEM;
                end
            end
            `OP_SW: begin
                ctrl.aluSrcB = `SRCB_IMM;
                ctrl.extOp = `EXT_SIGN;
                ctrl.memWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regNum_t;

    typedef struct packed {
        logic  valid;
        word_t address;  // byte address
        word_t data;
    } imemLoad_t;

    typedef struct packed {
        logic [3:0] aluOp;
        logic [1:0] aluSrcB;
        logic [1:0] extOp;
        logic [1:0] branch;
        logic [1:0] jump;
        logic       memRead;
        logic       memWrite;
        logic       regWrite;
        logic [1:0] regDst;
        logic [1:0] regSrc;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fdStage_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t rsData;
        word_t rtData;
        word_t imm;
        logic  linkTaken;
    } deStage_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t rtData;
        word_t aluResult;
        logic  linkTaken;
    } emStage_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t aluResult;
        word_t memData;
        logic  linkTaken;
    } mwStage_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        regNum_t regNum;
        word_t   data;
    } retire_t;

    typedef struct packed {
        logic  valid;
        word_t address;
        word_t data;
    } store_t;

endpackage

`default_nettype wire

/* rtl/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// primary opcodes
`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDIU   6'b001001
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011

// funct codes under OP_SPECIAL
`define FN_SLL  6'b000000
`define FN_JR   6'b001000
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_SLT  6'b101010

`define RT_BGEZAL 5'b10001  // rt field under OP_REGIMM

`define RESET_PC   32'h0000_0000
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// ctrl_t field encodings
`define ALU_ADDU 4'd0
`define ALU_SUBU 4'd1
`define ALU_AND  4'd2
`define ALU_OR   4'd3
`define ALU_SLT  4'd4
`define ALU_SLL  4'd5
`define ALU_LUI  4'd6

`define SRCB_RT    2'd0
`define SRCB_IMM   2'd1
`define SRCB_SHAMT 2'd2

`define EXT_ZERO  2'd0
`define EXT_SIGN  2'd1
`define EXT_UPPER 2'd2

`define BR_NONE   2'd0
`define BR_BEQ    2'd1
`define BR_BNE    2'd2
`define BR_BGEZAL 2'd3

`define JMP_NONE  2'd0
`define JMP_INDEX 2'd1
`define JMP_REG   2'd2

`define DST_RT 2'd0
`define DST_RD 2'd1
`define DST_RA 2'd2

`define WB_ALU  2'd0
`define WB_MEM  2'd1
`define WB_LINK 2'd2

`endif
